//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_wb_timer
FILELIST  ?= src.f
MDIR      ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(MDIR) --top-module $(TOP) -f $(FILELIST)
	out="$$(./$(MDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)

//--- dv/tb_wb_timer.sv
`timescale 1ns/1ps

module tb_wb_timer;

   import iob_timer_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int RST_CYCLES = 8;
   localparam int ACK_EDGES  = 2;   // request sampled, then ack taken
   localparam int ACK_LIMIT  = 16;
   localparam int TXN_CYCLES = 4;
   localparam int N_REGS     = 5;
   localparam int N_WORDS    = 16;
   localparam int SRAM_BASE  = 1 << SRAM_SEL_BIT;
   localparam int TMR_PRESC  = 3;
   localparam int TMR_CMP    = 5;
   localparam int TMR_WAIT   = (TMR_CMP + 1) * (TMR_PRESC + 1) + 3 * TXN_CYCLES;
   // every poll counted as a transfer
   localparam int N_TXN      = N_REGS + 3 * N_WORDS + 8 + 6 + 4 + 8 + TMR_WAIT;
   localparam int WATCHDOG_CYCLES = RST_CYCLES + N_TXN * (ACK_LIMIT + 2) + TMR_WAIT;

   logic              clk_i;
   logic              rst_i;
   logic [ADDR_W-1:0] wb_addr_i;
   logic [STRB_W-1:0] wb_select_i;
   logic              wb_we_i;
   logic              wb_cyc_i;
   logic              wb_stb_i;
   logic [DATA_W-1:0] wb_data_i;
   logic              wb_ack_o;
   logic [DATA_W-1:0] wb_data_o;
   logic              irq_o;

   int                value_errs;
   int                proto_errs;
   int                cycle_cnt;
   logic [31:0]       lfsr_q;
   logic [DATA_W-1:0] sram_model [N_WORDS];

   wb_timer_top DUT (
      .clk_i(clk_i), .rst_i(rst_i),
      .wb_addr_i(wb_addr_i), .wb_select_i(wb_select_i), .wb_we_i(wb_we_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_data_i(wb_data_i),
      .wb_ack_o(wb_ack_o), .wb_data_o(wb_data_o), .irq_o(irq_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   // one lfsr step per bit
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   function automatic logic [DATA_W-1:0] byte_merge(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [STRB_W-1:0] sel);
      logic [DATA_W-1:0] w;
      w = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (sel[b]) begin
            w[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return w;
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input csr_addr_e r);
      return ADDR_W'({r, 2'b00});
   endfunction

   function automatic logic [ADDR_W-1:0] sram_addr(input int i);
      return ADDR_W'(SRAM_BASE + 4 * i);
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         value_errs++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [STRB_W-1:0] sel, input logic [DATA_W-1:0] wdata,
                           output logic [DATA_W-1:0] rdata);
      int edges;
      edges = 0;
      rdata = '0;
      wb_addr_i   = addr;
      wb_select_i = sel;
      wb_we_i     = we;
      wb_data_i   = wdata;
      wb_cyc_i    = 1'b1;
      wb_stb_i    = 1'b1;
      do begin
         @(posedge clk_i);
         edges++;
         @(negedge clk_i);
      end while (!wb_ack_o && edges < ACK_LIMIT);
      if (!wb_ack_o) begin
         proto_errs++;
         $display("no ack for address %h within %0d cycles", addr, ACK_LIMIT);
      end else begin
         rdata = wb_data_o;
         @(posedge clk_i);  // master takes the ack here
         edges++;
         assert (edges == ACK_EDGES) else begin
            proto_errs++;
            $display("ack for address %h taken %0d cycles after request start, not %0d",
                     addr, edges, ACK_EDGES);
         end
         @(negedge clk_i);
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [STRB_W-1:0] sel,
                           input logic [DATA_W-1:0] data);
      logic [DATA_W-1:0] unused_rd;
      bus_xfer(1'b1, addr, sel, data, unused_rd);
   endtask

   task automatic wb_read(input logic [ADDR_W-1:0] addr, input logic [STRB_W-1:0] sel,
                          output logic [DATA_W-1:0] data);
      bus_xfer(1'b0, addr, sel, '0, data);
   endtask

   task automatic test_reset();
      logic [DATA_W-1:0] d;
      check_value("irq_o", {31'b0, irq_o}, 32'h0);
      check_value("wb_ack_o", {31'b0, wb_ack_o}, 32'h0);
      for (int r = 0; r < N_REGS; r++) begin
         wb_read(ADDR_W'(4 * r), '1, d);
         check_value("wb_data_o", d, '0);
      end
   endtask

   task automatic test_sram_bytes();
      logic [DATA_W-1:0] d;
      logic [31:0]       sel;
      for (int i = 0; i < N_WORDS; i++) begin
         rand_bits(DATA_W, d);
         wb_write(sram_addr(i), '1, d);  // known contents first
         sram_model[i] = d;
      end
      for (int i = 0; i < N_WORDS; i++) begin
         rand_bits(DATA_W, d);
         rand_bits(STRB_W, sel);
         wb_write(sram_addr(i), sel[STRB_W-1:0], d);
         sram_model[i] = byte_merge(sram_model[i], d, sel[STRB_W-1:0]);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         wb_read(sram_addr(i), '1, d);
         check_value("wb_data_o", d, sram_model[i]);
      end
   endtask

   task automatic test_read_mask();
      logic [DATA_W-1:0] d;
      logic [31:0]       sel;
      for (int i = 0; i < 8; i++) begin
         rand_bits(STRB_W, sel);
         wb_read(sram_addr(i), sel[STRB_W-1:0], d);
         check_value("wb_data_o", d, byte_merge('0, sram_model[i], sel[STRB_W-1:0]));
      end
   endtask

   task automatic test_regs();
      logic [DATA_W-1:0] v;
      logic [DATA_W-1:0] d;
      rand_bits(DATA_W, v);
      wb_write(reg_addr(REG_PRESCALE), '1, v);
      wb_read(reg_addr(REG_PRESCALE), '1, d);
      check_value("prescale", d, v & 32'h0000_FFFF);  // 16 bits stored
      rand_bits(DATA_W, v);
      wb_write(reg_addr(REG_COMPARE), '1, v);
      wb_read(reg_addr(REG_COMPARE), '1, d);
      check_value("compare", d, v);
      wb_write(reg_addr(REG_COUNT), '1, ~v);
      wb_read(reg_addr(REG_COUNT), '1, d);
      check_value("count", d, '0);  // timer never enabled yet
   endtask

   task automatic test_timer_irq();
      logic [DATA_W-1:0] d;
      int                start;
      wb_write(reg_addr(REG_PRESCALE), '1, DATA_W'(TMR_PRESC));
      wb_write(reg_addr(REG_COMPARE), '1, DATA_W'(TMR_CMP));
      start = cycle_cnt;
      wb_write(reg_addr(REG_CTRL), '1, 32'h1);
      d = '0;
      while (!d[STATUS_IRQ_BIT] && cycle_cnt - start <= TMR_WAIT) begin
         wb_read(reg_addr(REG_STATUS), '1, d);
      end
      assert (d[STATUS_IRQ_BIT]) else begin
         proto_errs++;
         $display("irq flag still clear %0d cycles after timer enable", TMR_WAIT);
      end
      check_value("irq_o", {31'b0, irq_o}, 32'h1);
      wb_read(reg_addr(REG_COUNT), '1, d);
      assert (d <= DATA_W'(TMR_CMP)) else begin
         value_errs++;
         $display("FAILED count: got %h, above compare %h", d, TMR_CMP);
      end
   endtask

   task automatic test_irq_clear();
      logic [DATA_W-1:0] d;
      wb_write(reg_addr(REG_CTRL), '1, 32'h0);  // stop, no new match
      wb_write(reg_addr(REG_STATUS), '1, 32'h1);
      check_value("irq_o", {31'b0, irq_o}, 32'h0);
      wb_read(reg_addr(REG_STATUS), '1, d);
      check_value("status", d, '0);
      wb_write(reg_addr(REG_CTRL), '1, 32'h2);
      wb_read(reg_addr(REG_COUNT), '1, d);
      check_value("count", d, '0);
      wb_read(reg_addr(REG_CTRL), '1, d);
      check_value("ctrl", d, '0);  // clear bit does not stick
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

   initial begin
      value_errs  = 0;
      proto_errs  = 0;
      lfsr_q      = 32'h7c86;
      rst_i       = 1'b1;
      wb_addr_i   = '0;
      wb_select_i = '0;
      wb_we_i     = 1'b0;
      wb_cyc_i    = 1'b0;
      wb_stb_i    = 1'b0;
      wb_data_i   = '0;
      repeat (RST_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      @(negedge clk_i);  // targets raise ready one cycle out of reset
      test_reset();
      test_sram_bytes();
      test_read_mask();
      test_regs();
      test_timer_irq();
      test_irq_clear();
      $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
      if (value_errs + proto_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- logic/iob_addr_split.sv
`timescale 1ns/1ps

module iob_addr_split (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic                             avalid_i,
   input  logic [iob_timer_pkg::ADDR_W-1:0] address_i,
   input  logic [iob_timer_pkg::DATA_W-1:0] rdata_reg_i,
   input  logic [iob_timer_pkg::DATA_W-1:0] rdata_mem_i,
   input  logic                             rvalid_reg_i,
   input  logic                             rvalid_mem_i,
   input  logic                             ready_reg_i,
   input  logic                             ready_mem_i,
   output logic                             avalid_reg_o,
   output logic                             avalid_mem_o,
   output logic                             ready_o,
   output logic                             rvalid_o,
   output logic [iob_timer_pkg::DATA_W-1:0] rdata_o
);

   import iob_timer_pkg::*;

   logic sel_mem;
   logic resp_mem_r;  // target of the last accepted request

   assign sel_mem = address_i[SRAM_SEL_BIT];

   assign avalid_reg_o = avalid_i & ~sel_mem;
   assign avalid_mem_o = avalid_i & sel_mem;
   assign ready_o      = sel_mem ? ready_mem_i : ready_reg_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         resp_mem_r <= 1'b0;
      end else if (avalid_i && ready_o) begin
         resp_mem_r <= sel_mem;
      end
   end

   // response comes back one cycle after acceptance
   assign rvalid_o = resp_mem_r ? rvalid_mem_i : rvalid_reg_i;
   assign rdata_o  = resp_mem_r ? rdata_mem_i : rdata_reg_i;

   a_one_responder : assert property (
      @(posedge clk_i) disable iff (rst_i)
      !(rvalid_reg_i && rvalid_mem_i)
   );

endmodule

//--- logic/iob_sram.sv
`timescale 1ns/1ps

module iob_sram #(
   parameter int SRAM_AW = 6  // word address bits
) (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic                             avalid_i,
   input  logic [iob_timer_pkg::ADDR_W-1:0] address_i,
   input  logic [iob_timer_pkg::DATA_W-1:0] wdata_i,
   input  logic [iob_timer_pkg::STRB_W-1:0] wstrb_i,
   output logic                             ready_o,
   output logic                             rvalid_o,
   output logic [iob_timer_pkg::DATA_W-1:0] rdata_o
);

   import iob_timer_pkg::*;

   logic [DATA_W-1:0]  mem [2**SRAM_AW];
   logic [SRAM_AW-1:0] word_addr;
   logic               ready_r;
   logic               accept;
   logic               rvalid_r;
   logic [DATA_W-1:0]  rdata_r;

   assign word_addr = address_i[SRAM_AW+1:2];
   assign accept    = avalid_i & ready_r;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ready_r  <= 1'b0;
         rvalid_r <= 1'b0;
      end else begin
         ready_r  <= 1'b1;
         rvalid_r <= accept & ~(|wstrb_i);
      end
   end

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < STRB_W; b++) begin
         if (accept && wstrb_i[b]) begin
            mem[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];  // per byte lane
         end
      end
      if (accept && !(|wstrb_i)) begin
         rdata_r <= mem[word_addr];
      end
   end

   assign ready_o  = ready_r;
   assign rvalid_o = rvalid_r;
   assign rdata_o  = rdata_r;

endmodule

//--- logic/iob_timer_pkg.sv
package iob_timer_pkg;

   // bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // set means scratch memory, clear means register block
   localparam int SRAM_SEL_BIT = 12;

   localparam int REG_AW = 3;  // register word offset bits

   typedef enum logic [REG_AW-1:0] {
      REG_CTRL     = 3'd0,
      REG_PRESCALE = 3'd1,
      REG_COMPARE  = 3'd2,
      REG_COUNT    = 3'd3,  // read only
      REG_STATUS   = 3'd4
   } csr_addr_e;

   localparam int PRESCALE_W = 16;

   // field positions
   localparam int CTRL_EN_BIT    = 0;
   localparam int CTRL_CLR_BIT   = 1;  // self-clearing
   localparam int STATUS_IRQ_BIT = 0;  // write one to clear

endpackage

//--- logic/iob_timer_regs.sv
`timescale 1ns/1ps

module iob_timer_regs (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  logic                                 avalid_i,
   input  logic [    iob_timer_pkg::ADDR_W-1:0] address_i,
   input  logic [    iob_timer_pkg::DATA_W-1:0] wdata_i,
   input  logic [    iob_timer_pkg::STRB_W-1:0] wstrb_i,
   input  logic [    iob_timer_pkg::DATA_W-1:0] count_i,
   input  logic                                 irq_flag_i,
   output logic                                 ready_o,
   output logic                                 rvalid_o,
   output logic [    iob_timer_pkg::DATA_W-1:0] rdata_o,
   output logic                                 enable_o,
   output logic                                 clear_o,
   output logic [iob_timer_pkg::PRESCALE_W-1:0] prescale_o,
   output logic [    iob_timer_pkg::DATA_W-1:0] compare_o,
   output logic                                 irq_clear_o
);

   import iob_timer_pkg::*;

   csr_addr_e             word_addr;
   logic                  ready_r;
   logic                  accept;
   logic                  wr_en;
   logic                  rd_en;
   logic                  enable_r;
   logic [PRESCALE_W-1:0] prescale_r;
   logic [DATA_W-1:0]     compare_r;
   logic [DATA_W-1:0]     rd_mux;
   logic [DATA_W-1:0]     rdata_r;
   logic                  rvalid_r;

   assign word_addr = csr_addr_e'(address_i[REG_AW+1:2]);
   assign accept    = avalid_i & ready_r;
   assign wr_en     = accept & (|wstrb_i);
   assign rd_en     = accept & ~(|wstrb_i);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ready_r <= 1'b0;
      end else begin
         ready_r <= 1'b1;  // never stalls
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_r   <= 1'b0;
         prescale_r <= '0;
         compare_r  <= '0;
      end else if (wr_en) begin
         case (word_addr)
            REG_CTRL: begin
               if (wstrb_i[0]) begin
                  enable_r <= wdata_i[CTRL_EN_BIT];
               end
            end
            REG_PRESCALE: begin
               for (int b = 0; b < PRESCALE_W / 8; b++) begin
                  if (wstrb_i[b]) begin
                     prescale_r[8*b +: 8] <= wdata_i[8*b +: 8];
                  end
               end
            end
            REG_COMPARE: begin
               for (int b = 0; b < STRB_W; b++) begin
                  if (wstrb_i[b]) begin
                     compare_r[8*b +: 8] <= wdata_i[8*b +: 8];
                  end
               end
            end
            default: ;  // count and status have no storage here
         endcase
      end
   end

   // one-cycle pulses, since avalid lasts a single cycle
   assign clear_o = wr_en & (word_addr == REG_CTRL) & wstrb_i[0] & wdata_i[CTRL_CLR_BIT];
   assign irq_clear_o = wr_en & (word_addr == REG_STATUS) & wstrb_i[0]
                        & wdata_i[STATUS_IRQ_BIT];

   always_comb begin
      rd_mux = '0;
      case (word_addr)
         REG_CTRL:     rd_mux[CTRL_EN_BIT] = enable_r;
         REG_PRESCALE: rd_mux[PRESCALE_W-1:0] = prescale_r;
         REG_COMPARE:  rd_mux = compare_r;
         REG_COUNT:    rd_mux = count_i;
         REG_STATUS:   rd_mux[STATUS_IRQ_BIT] = irq_flag_i;
         default:      rd_mux = '0;  // unmapped
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_r <= 1'b0;
      end else begin
         rvalid_r <= rd_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_r <= rd_mux;
      end
   end

   assign ready_o    = ready_r;
   assign rvalid_o   = rvalid_r;
   assign rdata_o    = rdata_r;
   assign enable_o   = enable_r;
   assign prescale_o = prescale_r;
   assign compare_o  = compare_r;

endmodule

//--- logic/timer_core.sv
`timescale 1ns/1ps

module timer_core (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  logic                                 enable_i,
   input  logic                                 clear_i,
   input  logic [iob_timer_pkg::PRESCALE_W-1:0] prescale_i,
   input  logic [    iob_timer_pkg::DATA_W-1:0] compare_i,
   input  logic                                 irq_clear_i,
   output logic [    iob_timer_pkg::DATA_W-1:0] count_o,
   output logic                                 irq_flag_o
);

   import iob_timer_pkg::*;

   logic [PRESCALE_W-1:0] presc_cnt;
   logic [DATA_W-1:0]     count_r;
   logic                  irq_flag_r;
   logic                  tick;
   logic                  match;

   // >= so a lowered prescale takes effect at once
   assign tick  = enable_i & ~clear_i & (presc_cnt >= prescale_i);
   assign match = tick & (count_r == compare_i);

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         presc_cnt <= '0;
      end else if (tick) begin
         presc_cnt <= '0;
      end else if (enable_i) begin
         presc_cnt <= presc_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         count_r <= '0;
      end else if (match) begin
         count_r <= '0;  // wrap at compare
      end else if (tick) begin
         count_r <= count_r + 1'b1;
      end
   end

   // sticky, a match on the clearing edge keeps it set
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         irq_flag_r <= 1'b0;
      end else if (match) begin
         irq_flag_r <= 1'b1;
      end else if (irq_clear_i) begin
         irq_flag_r <= 1'b0;
      end
   end

   assign count_o    = count_r;
   assign irq_flag_o = irq_flag_r;

endmodule

//--- logic/wb_iob_bridge.sv
`timescale 1ns/1ps

module wb_iob_bridge (
   input  logic                             clk_i,
   input  logic                             rst_i,
   // wishbone slave
   input  logic [iob_timer_pkg::ADDR_W-1:0] wb_addr_i,
   input  logic [iob_timer_pkg::STRB_W-1:0] wb_select_i,
   input  logic                             wb_we_i,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic [iob_timer_pkg::DATA_W-1:0] wb_data_i,
   output logic                             wb_ack_o,
   output logic [iob_timer_pkg::DATA_W-1:0] wb_data_o,
   // iob master
   output logic                             iob_avalid_o,
   output logic [iob_timer_pkg::ADDR_W-1:0] iob_address_o,
   output logic [iob_timer_pkg::DATA_W-1:0] iob_wdata_o,
   output logic [iob_timer_pkg::STRB_W-1:0] iob_wstrb_o,
   input  logic                             iob_rvalid_i,
   input  logic [iob_timer_pkg::DATA_W-1:0] iob_rdata_i,
   input  logic                             iob_ready_i
);

   import iob_timer_pkg::*;

   logic              wb_req;
   logic              wack;
   logic              wack_r;
   logic [DATA_W-1:0] data_mask;

   assign wb_req = wb_cyc_i & wb_stb_i;

   // drop the request in the ack cycle so it is not issued twice
   assign iob_avalid_o  = wb_req & ~wb_ack_o;
   assign iob_address_o = wb_addr_i;
   assign iob_wdata_o   = wb_data_i;
   assign iob_wstrb_o   = wb_we_i ? wb_select_i : '0;  // zero strobes mean read

   assign wack = iob_avalid_o & iob_ready_i & (|iob_wstrb_o);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wack_r <= 1'b0;
      end else begin
         wack_r <= wack;
      end
   end

   // reads finish on rvalid, writes one cycle after acceptance
   assign wb_ack_o = wack_r | iob_rvalid_i;

   for (genvar b = 0; b < STRB_W; b++) begin : g_mask
      assign data_mask[8*b +: 8] = {8{wb_select_i[b]}};
   end

   assign wb_data_o = iob_rdata_i & data_mask;  // unselected lanes read zero

   // one ack per cycle, master lowers stb right after it
   a_ack_single : assert property (
      @(posedge clk_i) disable iff (rst_i)
      wb_ack_o |=> !wb_ack_o
   );

   // every accepted request gets its ack on the next cycle
   a_ack_after_accept : assert property (
      @(posedge clk_i) disable iff (rst_i)
      iob_avalid_o && iob_ready_i |=> wb_ack_o
   );

endmodule

//--- logic/wb_timer_top.sv
`timescale 1ns/1ps

module wb_timer_top (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic [iob_timer_pkg::ADDR_W-1:0] wb_addr_i,
   input  logic [iob_timer_pkg::STRB_W-1:0] wb_select_i,
   input  logic                             wb_we_i,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic [iob_timer_pkg::DATA_W-1:0] wb_data_i,
   output logic                             wb_ack_o,
   output logic [iob_timer_pkg::DATA_W-1:0] wb_data_o,
   output logic                             irq_o
);

   import iob_timer_pkg::*;

   // bridge side of the iob bus
   logic                  iob_avalid;
   logic [ADDR_W-1:0]     iob_address;
   logic [DATA_W-1:0]     iob_wdata;
   logic [STRB_W-1:0]     iob_wstrb;
   logic                  iob_ready;
   logic                  iob_rvalid;
   logic [DATA_W-1:0]     iob_rdata;
   // per target
   logic                  avalid_reg;
   logic                  avalid_mem;
   logic                  ready_reg;
   logic                  ready_mem;
   logic                  rvalid_reg;
   logic                  rvalid_mem;
   logic [DATA_W-1:0]     rdata_reg;
   logic [DATA_W-1:0]     rdata_mem;
   // timer control
   logic                  tmr_enable;
   logic                  tmr_clear;
   logic [PRESCALE_W-1:0] tmr_prescale;
   logic [DATA_W-1:0]     tmr_compare;
   logic                  tmr_irq_clear;
   logic [DATA_W-1:0]     tmr_count;

   wb_iob_bridge u_bridge (
      .clk_i(clk_i), .rst_i(rst_i),
      .wb_addr_i(wb_addr_i), .wb_select_i(wb_select_i), .wb_we_i(wb_we_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_data_i(wb_data_i),
      .wb_ack_o(wb_ack_o), .wb_data_o(wb_data_o),
      .iob_avalid_o(iob_avalid), .iob_address_o(iob_address),
      .iob_wdata_o(iob_wdata), .iob_wstrb_o(iob_wstrb),
      .iob_rvalid_i(iob_rvalid), .iob_rdata_i(iob_rdata), .iob_ready_i(iob_ready)
   );

   iob_addr_split u_split (
      .clk_i(clk_i), .rst_i(rst_i),
      .avalid_i(iob_avalid), .address_i(iob_address),
      .rdata_reg_i(rdata_reg), .rdata_mem_i(rdata_mem),
      .rvalid_reg_i(rvalid_reg), .rvalid_mem_i(rvalid_mem),
      .ready_reg_i(ready_reg), .ready_mem_i(ready_mem),
      .avalid_reg_o(avalid_reg), .avalid_mem_o(avalid_mem),
      .ready_o(iob_ready), .rvalid_o(iob_rvalid), .rdata_o(iob_rdata)
   );

   iob_timer_regs u_regs (
      .clk_i(clk_i), .rst_i(rst_i),
      .avalid_i(avalid_reg), .address_i(iob_address),
      .wdata_i(iob_wdata), .wstrb_i(iob_wstrb),
      .count_i(tmr_count), .irq_flag_i(irq_o),
      .ready_o(ready_reg), .rvalid_o(rvalid_reg), .rdata_o(rdata_reg),
      .enable_o(tmr_enable), .clear_o(tmr_clear), .prescale_o(tmr_prescale),
      .compare_o(tmr_compare), .irq_clear_o(tmr_irq_clear)
   );

   timer_core u_timer (
      .clk_i(clk_i), .rst_i(rst_i),
      .enable_i(tmr_enable), .clear_i(tmr_clear),
      .prescale_i(tmr_prescale), .compare_i(tmr_compare),
      .irq_clear_i(tmr_irq_clear),
      .count_o(tmr_count), .irq_flag_o(irq_o)  // flag is the level irq
   );

   iob_sram u_sram (
      .clk_i(clk_i), .rst_i(rst_i),
      .avalid_i(avalid_mem), .address_i(iob_address),
      .wdata_i(iob_wdata), .wstrb_i(iob_wstrb),
      .ready_o(ready_mem), .rvalid_o(rvalid_mem), .rdata_o(rdata_mem)
   );

endmodule

//--- src.f
logic/iob_timer_pkg.sv
logic/wb_iob_bridge.sv
logic/iob_addr_split.sv
logic/iob_timer_regs.sv
logic/timer_core.sv
logic/iob_sram.sv
logic/wb_timer_top.sv
dv/tb_wb_timer.sv
